// File: octavo_defines.svh
//------------------------------
// Widths and memory map of the four-thread core
// Thread count is fixed by the pipeline depth
//------------------------------
`ifndef OCTAVO_DEFINES_SVH
`define OCTAVO_DEFINES_SVH

`define WORD_WIDTH        16
`define ADDR_WIDTH        8
`define OPCODE_WIDTH      4

`define THREAD_COUNT      4
`define THREAD_BITS       2

// Shared addresses, never translated
`define IO_BASE           8'hF0
`define IO_IN_ADDR        8'hF0
`define IO_OUT_ADDR       8'hF8
`define OFFSET_ADDR       8'hF9

// Reset spacing of per-thread code and data
`define THREAD_CODE_SPAN  64
`define THREAD_DATA_SPAN  60

`endif

// File: octavo_isa_pkg.sv
//------------------------------
// Instruction format: opcode, D, A, B (28 bits)
//------------------------------
`default_nettype none
`include "octavo_defines.svh"

package octavo_isa_pkg;

    // Codes 7 to 15 all decode to NOP
    typedef enum logic [`OPCODE_WIDTH-1:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        JMP = 4'd5,
        JZ  = 4'd6,
        NOP = 4'd7
    } opcode_e;

    typedef logic [`OPCODE_WIDTH-1:0] op_field_t;
    typedef logic [`ADDR_WIDTH-1:0]   operand_field_t;

    typedef struct packed {
        op_field_t      op;
        operand_field_t d;
        operand_field_t a;
        operand_field_t b;
    } instr_t;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_JMP,
        BR_JZ
    } branch_e;

    typedef struct packed {
        opcode_e op;
        logic    writes;
        branch_e branch;
    } uop_t;

    typedef struct packed {
        logic                    valid;
        logic [`THREAD_BITS-1:0] thread;
        uop_t                    uop;
        operand_field_t          d;
        operand_field_t          a;
        operand_field_t          b;
    } issue_t;

endpackage

`default_nettype wire

// File: octavo_mem_pkg.sv
//------------------------------
// Data-side types, needs octavo_isa_pkg compiled first
//------------------------------
`default_nettype none
`include "octavo_defines.svh"

package octavo_mem_pkg;

    typedef logic [`WORD_WIDTH-1:0]  word_t;
    typedef logic [`ADDR_WIDTH-1:0]  addr_t;
    typedef logic [`THREAD_BITS-1:0] thread_t;

    typedef enum logic [1:0] {
        MEM,
        IO,
        OFFSET,
        NONE
    } kind_e;

    typedef struct packed {
        kind_e kind;
        addr_t addr;
    } operand_t;

    typedef struct packed {
        logic                 valid;
        thread_t              thread;
        octavo_isa_pkg::uop_t uop;
        operand_t             a;
        operand_t             b;
        operand_t             d;
    } xlat_t;

    typedef enum logic {
        TGT_INSTR,
        TGT_DATA
    } target_e;

    // Data loads keep only the low word of data
    typedef struct packed {
        target_e                target;
        addr_t                  addr;
        octavo_isa_pkg::instr_t data;
    } load_t;

    typedef struct packed {
        thread_t thread;
        addr_t   value;
    } offset_wr_t;

endpackage

`default_nettype wire

// File: control_path.sv
//------------------------------
// Round-robin fetch, one thread per cycle
// Load port only serviced while IDLE
//------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "octavo_defines.svh"

module control_path (
    input  wire                         clock,
    input  wire                         arst_n,
    input  wire                         start,
    input  wire                         load_wren,
    input  wire octavo_mem_pkg::load_t  load,
    input  wire                         a_zero,
    output octavo_isa_pkg::issue_t      issue
);
    import octavo_isa_pkg::*;
    import octavo_mem_pkg::*;

    typedef enum logic {
        IDLE,
        RUN
    } state_e;

    state_e  state;
    thread_t fetch_thread;
    addr_t   pc [`THREAD_COUNT];
    instr_t  imem [2**`ADDR_WIDTH];

    logic    valid_q;
    thread_t thread_q;
    instr_t  instr_q;
    uop_t    uop;

    branch_e br_kind;
    thread_t br_thread;
    addr_t   br_target;
    logic    br_taken;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else if (state == IDLE && start) begin
            state <= RUN;
        end
    end

    // ------------------------------
    // Fetch
    // ------------------------------
    always_ff @(posedge clock) begin
        if (load_wren && load.target == TGT_INSTR) begin
            imem[load.addr] <= load.data;
        end
        instr_q  <= imem[pc[fetch_thread]];
        thread_q <= fetch_thread;
    end

    assign br_taken = (br_kind == BR_JMP) || (br_kind == BR_JZ && a_zero);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q      <= 1'b0;
            fetch_thread <= '0;
            for (int t = 0; t < `THREAD_COUNT; t++) begin
                pc[t] <= addr_t'(t * `THREAD_CODE_SPAN);
            end
        end else begin
            valid_q <= (state == RUN);
            if (state == RUN) begin
                fetch_thread     <= fetch_thread + 1'b1;
                pc[fetch_thread] <= pc[fetch_thread] + 1'b1;
            end
            // Branch thread trails the fetch by two, so the PCs never collide
            if (br_taken) begin
                pc[br_thread] <= br_target;
            end
        end
    end

    // ------------------------------
    // Decode and branch stage
    // ------------------------------
    always_comb begin
        uop.op     = NOP;
        uop.writes = 1'b0;
        uop.branch = BR_NONE;
        case (instr_q.op)
            ADD, SUB, AND, OR, XOR: begin
                uop.op     = opcode_e'(instr_q.op);
                uop.writes = 1'b1;
            end
            JMP: begin
                uop.op     = JMP;
                uop.branch = BR_JMP;
            end
            JZ: begin
                uop.op     = JZ;
                uop.branch = BR_JZ;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        issue.valid  = valid_q;
        issue.thread = thread_q;
        issue.uop    = uop;
        issue.d      = instr_q.d;
        issue.a      = instr_q.a;
        issue.b      = instr_q.b;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            br_kind <= BR_NONE;
        end else begin
            br_kind <= issue.valid ? uop.branch : BR_NONE;
        end
    end

    always_ff @(posedge clock) begin
        br_thread <= thread_q;
        br_target <= instr_q.d;
    end

    // Loads would race with fetch and writeback once running
    assert property (@(posedge clock) disable iff (!arst_n)
        state == RUN |-> !load_wren)
        else $error("load_wren asserted while running");

endmodule

`default_nettype wire

// File: address_translation.sv
//------------------------------
// Per-thread offsets apply to addresses below IO_BASE only
//------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "octavo_defines.svh"

module address_translation (
    input  wire                              clock,
    input  wire                              arst_n,
    input  wire octavo_isa_pkg::issue_t      issue,
    input  wire                              offset_wr,
    input  wire octavo_mem_pkg::offset_wr_t  offset_wr_data,
    output octavo_mem_pkg::xlat_t            xlat
);
    import octavo_isa_pkg::*;
    import octavo_mem_pkg::*;

    addr_t offset [`THREAD_COUNT];
    addr_t thread_offset;

    function automatic operand_t map_source(operand_field_t raw, addr_t base);
        operand_t res;
        res.addr = raw;
        if (raw < `IO_BASE) begin
            res.kind = MEM;
            res.addr = raw + base;
        end else if (raw == `IO_IN_ADDR) begin
            res.kind = IO;
        end else begin
            res.kind = NONE;
        end
        return res;
    endfunction

    function automatic operand_t map_dest(operand_field_t raw, addr_t base);
        operand_t res;
        res.addr = raw;
        if (raw < `IO_BASE) begin
            res.kind = MEM;
            res.addr = raw + base;
        end else if (raw == `IO_OUT_ADDR) begin
            res.kind = IO;
        end else if (raw == `OFFSET_ADDR) begin
            res.kind = OFFSET;
        end else begin
            res.kind = NONE;
        end
        return res;
    endfunction

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int t = 0; t < `THREAD_COUNT; t++) begin
                offset[t] <= addr_t'(t * `THREAD_DATA_SPAN);
            end
        end else if (offset_wr) begin
            offset[offset_wr_data.thread] <= offset_wr_data.value;
        end
    end

    assign thread_offset = offset[issue.thread];

    always_comb begin
        xlat.valid  = issue.valid;
        xlat.thread = issue.thread;
        xlat.uop    = issue.uop;
        xlat.a      = map_source(issue.a, thread_offset);
        xlat.b      = map_source(issue.b, thread_offset);
        xlat.d      = map_dest(issue.d, thread_offset);
    end

    // An offset update lands before its own thread translates again
    assert property (@(posedge clock) disable iff (!arst_n)
        offset_wr && issue.valid |-> offset_wr_data.thread != issue.thread)
        else $error("offset write meets a translation of the same thread");

endmodule

`default_nettype wire

// File: data_path.sv
//------------------------------
// A and B memories hold the same data, one read port each
//------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "octavo_defines.svh"

module data_path (
    input  wire                              clock,
    input  wire                              arst_n,
    input  wire octavo_mem_pkg::xlat_t       xlat,
    input  wire                              load_wren,
    input  wire octavo_mem_pkg::load_t       load,
    input  wire octavo_mem_pkg::word_t       io_in,
    output logic                             io_rden,
    output octavo_mem_pkg::word_t            io_out,
    output logic                             io_wren,
    output logic                             a_zero,
    output logic                             offset_wr,
    output octavo_mem_pkg::offset_wr_t       offset_wr_data
);
    import octavo_isa_pkg::*;
    import octavo_mem_pkg::*;

    word_t    mem_a [2**`ADDR_WIDTH];
    word_t    mem_b [2**`ADDR_WIDTH];

    logic     rd_valid;
    uop_t     rd_uop;
    kind_e    rd_a_kind;
    kind_e    rd_b_kind;
    operand_t rd_d;
    thread_t  rd_thread;
    word_t    rd_a_mem;
    word_t    rd_b_mem;
    word_t    rd_io;

    word_t    a_val;
    word_t    b_val;
    word_t    alu_result;

    kind_e    wr_kind;
    addr_t    wr_addr;
    word_t    wr_result;
    thread_t  wr_thread;

    logic     mem_wren;
    addr_t    mem_waddr;
    word_t    mem_wdata;

    function automatic word_t pick(kind_e kind, word_t mem_word, word_t io_word);
        case (kind)
            MEM:     return mem_word;
            IO:      return io_word;
            default: return '0;
        endcase
    endfunction

    // ------------------------------
    // Operand read
    // ------------------------------
    // A and B both reading io_in share a single strobe
    assign io_rden = xlat.valid && (xlat.a.kind == IO || xlat.b.kind == IO);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= xlat.valid;
        end
    end

    always_ff @(posedge clock) begin
        rd_a_mem  <= mem_a[xlat.a.addr];
        rd_b_mem  <= mem_b[xlat.b.addr];
        rd_io     <= io_in;
        rd_uop    <= xlat.uop;
        rd_a_kind <= xlat.a.kind;
        rd_b_kind <= xlat.b.kind;
        rd_d      <= xlat.d;
        rd_thread <= xlat.thread;
    end

    assign a_val  = pick(rd_a_kind, rd_a_mem, rd_io);
    assign b_val  = pick(rd_b_kind, rd_b_mem, rd_io);
    assign a_zero = (a_val == '0);

    // ------------------------------
    // ALU and writeback
    // ------------------------------
    always_comb begin
        case (rd_uop.op)
            ADD:     alu_result = a_val + b_val;
            SUB:     alu_result = a_val - b_val;
            AND:     alu_result = a_val & b_val;
            OR:      alu_result = a_val | b_val;
            XOR:     alu_result = a_val ^ b_val;
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_kind <= NONE;
        end else begin
            wr_kind <= (rd_valid && rd_uop.writes) ? rd_d.kind : NONE;
        end
    end

    always_ff @(posedge clock) begin
        wr_addr   <= rd_d.addr;
        wr_result <= alu_result;
        wr_thread <= rd_thread;
    end

    assign io_wren               = (wr_kind == IO);
    assign io_out                = wr_result;
    assign offset_wr             = (wr_kind == OFFSET);
    assign offset_wr_data.thread = wr_thread;
    assign offset_wr_data.value  = wr_result[`ADDR_WIDTH-1:0];

    // External loads use raw addresses
    assign mem_wren  = (wr_kind == MEM) || (load_wren && load.target == TGT_DATA);
    assign mem_waddr = (wr_kind == MEM) ? wr_addr : load.addr;
    assign mem_wdata = (wr_kind == MEM) ? wr_result : load.data[`WORD_WIDTH-1:0];

    always_ff @(posedge clock) begin
        if (mem_wren) begin
            mem_a[mem_waddr] <= mem_wdata;
            mem_b[mem_waddr] <= mem_wdata;
        end
    end

    // A load landing during an I/O write means the core was loaded while running
    assert property (@(posedge clock) disable iff (!arst_n)
        !(io_wren && mem_wren))
        else $error("io_wren and memory write in the same cycle");

endmodule

`default_nettype wire

// File: scalar_core.sv
//------------------------------
// Load memories while idle, then pulse start once
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module scalar_core (
    input  wire                          clock,
    input  wire                          arst_n,
    input  wire                          start,
    input  wire                          load_wren,
    input  wire octavo_mem_pkg::load_t   load,
    input  wire octavo_mem_pkg::word_t   io_in,
    output logic                         io_rden,
    output octavo_mem_pkg::word_t        io_out,
    output logic                         io_wren
);
    import octavo_isa_pkg::*;
    import octavo_mem_pkg::*;

    issue_t     issue;
    xlat_t      xlat;
    logic       a_zero;
    logic       offset_wr;
    offset_wr_t offset_wr_data;

    control_path i_control_path (
        .clock          (clock),
        .arst_n         (arst_n),
        .start          (start),
        .load_wren      (load_wren),
        .load           (load),
        .a_zero         (a_zero),
        .issue          (issue)
    );

    address_translation i_address_translation (
        .clock          (clock),
        .arst_n         (arst_n),
        .issue          (issue),
        .offset_wr      (offset_wr),
        .offset_wr_data (offset_wr_data),
        .xlat           (xlat)
    );

    data_path i_data_path (
        .clock          (clock),
        .arst_n         (arst_n),
        .xlat           (xlat),
        .load_wren      (load_wren),
        .load           (load),
        .io_in          (io_in),
        .io_rden        (io_rden),
        .io_out         (io_out),
        .io_wren        (io_wren),
        .a_zero         (a_zero),
        .offset_wr      (offset_wr),
        .offset_wr_data (offset_wr_data)
    );

endmodule

`default_nettype wire

// File: tb_scalar_core.sv
//------------------------------
// Random per-thread programs checked against an ISA model
// Forward branches only, so each thread ends in its self-loop
//------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "octavo_defines.svh"

module tb_scalar_core;
    import octavo_isa_pkg::*;
    import octavo_mem_pkg::*;

    localparam int    CONST_SLOT   = 15;
    localparam int    RUN_TIMEOUT  = 4000;
    localparam int    TAIL_CYCLES  = 200;
    localparam addr_t UNMAPPED_SRC = 8'hF5;
    localparam addr_t UNMAPPED_DST = 8'hFA;

    logic  clock;
    logic  arst_n;
    logic  start;
    logic  load_wren;
    load_t load;
    word_t io_in;
    logic  io_rden;
    word_t io_out;
    logic  io_wren;

    logic [31:0] lfsr;
    instr_t      imem_img [2**`ADDR_WIDTH];
    word_t       data_img [2**`ADDR_WIDTH];
    word_t       model_mem [2**`ADDR_WIDTH];
    addr_t       loop_pc [`THREAD_COUNT];
    int          prog_len [`THREAD_COUNT];
    word_t       exp_out [$];
    word_t       io_seed;
    int          model_reads;
    int          rden_count;
    logic        running;

    scalar_core i_dut (
        .clock     (clock),
        .arst_n    (arst_n),
        .start     (start),
        .load_wren (load_wren),
        .load      (load),
        .io_in     (io_in),
        .io_rden   (io_rden),
        .io_out    (io_out),
        .io_wren   (io_wren)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic fail_run(string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "stopping on first error");
    endtask

    task automatic compare(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("Fail %s expected %0h actual %0h", name, expected, actual));
        end
    endtask

    // Taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int rand_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic int rand_below(int n);
        return rand_bits(10) % n;
    endfunction

    function automatic addr_t pick_source();
        int sel;
        sel = rand_below(8);
        if (sel < 6) return addr_t'(rand_below(16));
        if (sel == 6) return `IO_IN_ADDR;
        return UNMAPPED_SRC;
    endfunction

    function automatic addr_t pick_dest();
        int sel;
        sel = rand_below(8);
        if (sel < 4) return addr_t'(rand_below(16));
        if (sel < 7) return `IO_OUT_ADDR;
        return UNMAPPED_DST;
    endfunction

    // ------------------------------
    // Program and data generation
    // ------------------------------
    task automatic build_programs();
        int        n;
        int        sel;
        int        base;
        op_field_t op;
        addr_t     d;
        addr_t     a;
        addr_t     b;
        for (int i = 0; i < 2**`ADDR_WIDTH; i++) begin
            data_img[i] = word_t'(rand_bits(16));
            imem_img[i] = '0;
        end
        for (int t = 0; t < `THREAD_COUNT; t++) begin
            base = t * `THREAD_CODE_SPAN;
            n    = 4 + rand_below(16);
            // First instruction moves the thread's data window by 0 to 44 words
            data_img[t * `THREAD_DATA_SPAN + CONST_SLOT] =
                word_t'(t * `THREAD_DATA_SPAN + rand_below(45));
            imem_img[base] = {op_field_t'(ADD), `OFFSET_ADDR, addr_t'(CONST_SLOT), UNMAPPED_SRC};
            for (int i = 1; i <= n; i++) begin
                sel = rand_below(16);
                a   = pick_source();
                b   = pick_source();
                d   = pick_dest();
                if (sel < 9) begin
                    op = op_field_t'(sel % 5);
                end else if (sel < 13) begin
                    op = (sel < 11) ? op_field_t'(JMP) : op_field_t'(JZ);
                    d  = addr_t'(base + i + 1 + rand_below(n + 1 - i));
                end else begin
                    op = op_field_t'(7 + rand_below(9));
                end
                imem_img[base + i] = {op, d, a, b};
            end
            loop_pc[t]  = addr_t'(base + n + 1);
            prog_len[t] = n + 2;
            imem_img[base + n + 1] = {op_field_t'(JMP), loop_pc[t], 8'h00, 8'h00};
        end
    endtask

    // ------------------------------
    // ISA model
    // ------------------------------
    function automatic word_t operand_value(addr_t raw, addr_t off, word_t in_val);
        addr_t phys;
        phys = raw + off;
        if (raw < `IO_BASE) return model_mem[phys];
        if (raw == `IO_IN_ADDR) return in_val;
        return '0;
    endfunction

    task automatic run_model();
        addr_t  pc [`THREAD_COUNT];
        addr_t  off [`THREAD_COUNT];
        instr_t ins;
        word_t  a_val;
        word_t  b_val;
        word_t  res;
        word_t  in_val;
        addr_t  phys;
        logic   all_done;
        int     rounds;
        for (int t = 0; t < `THREAD_COUNT; t++) begin
            pc[t]  = addr_t'(t * `THREAD_CODE_SPAN);
            off[t] = addr_t'(t * `THREAD_DATA_SPAN);
        end
        for (int i = 0; i < 2**`ADDR_WIDTH; i++) begin
            model_mem[i] = data_img[i];
        end
        model_reads = 0;
        rounds      = 0;
        all_done    = 1'b0;
        // One instruction per thread per round, as the hardware issues them
        while (!all_done) begin
            all_done = 1'b1;
            rounds++;
            if (rounds > 64) fail_run("model never reached every self-loop");
            for (int t = 0; t < `THREAD_COUNT; t++) begin
                if (pc[t] != loop_pc[t]) begin
                    all_done = 1'b0;
                    ins      = imem_img[pc[t]];
                    in_val   = io_seed + word_t'(model_reads);
                    if (ins.a == `IO_IN_ADDR || ins.b == `IO_IN_ADDR) model_reads++;
                    a_val = operand_value(ins.a, off[t], in_val);
                    b_val = operand_value(ins.b, off[t], in_val);
                    res   = '0;
                    pc[t] = pc[t] + 8'd1;
                    case (ins.op)
                        ADD: res = a_val + b_val;
                        SUB: res = a_val - b_val;
                        AND: res = a_val & b_val;
                        OR:  res = a_val | b_val;
                        XOR: res = a_val ^ b_val;
                        JMP: pc[t] = ins.d;
                        JZ:  if (a_val == '0) pc[t] = ins.d;
                        default: ;
                    endcase
                    if (ins.op <= op_field_t'(XOR)) begin
                        phys = ins.d + off[t];
                        if (ins.d < `IO_BASE) model_mem[phys] = res;
                        else if (ins.d == `IO_OUT_ADDR) exp_out.push_back(res);
                        else if (ins.d == `OFFSET_ADDR) off[t] = res[7:0];
                    end
                end
            end
        end
    endtask

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic load_word(target_e target, addr_t addr, instr_t data);
        load.target = target;
        load.addr   = addr;
        load.data   = data;
        load_wren   = 1'b1;
        next_cycle();
        load_wren   = 1'b0;
    endtask

    // io_in advances once per strobe, just after the edge that consumed it
    initial begin : io_monitor
        io_in      = '0;
        rden_count = 0;
        forever begin
            @(negedge clock);
            if (!running) begin
                compare("io_rden before start", 32'd0, 32'(io_rden));
                compare("io_wren before start", 32'd0, 32'(io_wren));
            end
            if (io_rden) begin
                rden_count++;
                if (rden_count > model_reads) fail_run("more io_rden strobes than model reads");
            end
            if (io_wren) begin
                if (exp_out.size() == 0) fail_run("io_wren with no io_out value left to expect");
                compare("io_out", 32'(exp_out.pop_front()), 32'(io_out));
            end
            @(posedge clock);
            #2;
            io_in = io_seed + word_t'(rden_count);
        end
    end

    initial begin
        int cycles;
        arst_n    = 1'b0;
        start     = 1'b0;
        load_wren = 1'b0;
        load      = '0;
        running   = 1'b0;
        lfsr      = 32'hf792fbe3;
        io_seed   = word_t'(rand_bits(16));
        build_programs();
        run_model();

        repeat (10) @(posedge clock);
        #2;
        arst_n = 1'b1;
        next_cycle();

        for (int i = 0; i < `IO_BASE; i++) begin
            load_word(TGT_DATA, addr_t'(i), instr_t'(28'(data_img[i])));
        end
        for (int t = 0; t < `THREAD_COUNT; t++) begin
            for (int i = 0; i < prog_len[t]; i++) begin
                load_word(TGT_INSTR, addr_t'(t * `THREAD_CODE_SPAN + i),
                          imem_img[t * `THREAD_CODE_SPAN + i]);
            end
        end
        repeat (20) next_cycle();

        start   = 1'b1;
        running = 1'b1;
        next_cycle();
        start   = 1'b0;

        cycles = 0;
        while (exp_out.size() != 0 || rden_count != model_reads) begin
            next_cycle();
            cycles++;
            if (cycles > RUN_TIMEOUT) fail_run("timeout waiting for expected I/O activity");
        end
        // Every thread sits in its self-loop, so the port must stay quiet
        repeat (TAIL_CYCLES) next_cycle();

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
octavo_isa_pkg.sv
octavo_mem_pkg.sv
control_path.sv
address_translation.sv
data_path.sv
scalar_core.sv
tb_scalar_core.sv

// File: run_sim.sh
#!/bin/sh
# Compile the RTL and testbench with Verilator, then run the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_scalar_core \
    -o tb_scalar_core
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

sim_output=$(./obj_dir/tb_scalar_core 2>&1)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "Finished with no errors"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1
